// File: build.f
common/capture_pkg.sv
common/capture_ifs.sv
capture/capture_ingress.sv
capture/capture_writer.sv
capture/capture_ram.sv
design/capture_readout.sv
design/packet_capture.sv
bench/clock_gen.sv
bench/capture_asserts.sv
bench/capture_checker.sv
bench/tb_packet_capture.sv

// File: run.sh
#!/bin/sh
rm -f sim.log && \
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_packet_capture -f build.f -o sim_packet_capture > sim.log 2>&1 && \
./obj_dir/sim_packet_capture +verilator+error+limit+1000 >> sim.log 2>&1 || \
echo "Build or simulation ended with an error"
grep -q "^Simulation passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: bench/tb_packet_capture.sv
module tb_packet_capture;
    timeunit 1ns;
    timeprecision 100ps;
    import capture_pkg::*;

    // Run bound from the longest packets with the widest gaps, full read
    // sweeps and a drain per test
    localparam int FILL_LIMIT    = 150;
    localparam int NUM_PACKETS   = 1 + 20 + 4 + FILL_LIMIT + 3;
    localparam int MAX_PKT_WORDS = 12;
    localparam int MAX_GAP       = 3;
    localparam int NUM_TESTS     = 5;
    localparam int CYCLE_LIMIT   = NUM_PACKETS * (MAX_PKT_WORDS + MAX_GAP + 2)
                                 + NUM_TESTS * (MEM_WORDS + 60) + 1000;

    logic                     clk;
    logic                     reset;
    logic                     en;
    logic                     pkt_valid;
    logic [DATA_WIDTH-1:0]    pkt_data;
    logic                     pkt_eop;
    logic [2:0]               pkt_mty;
    logic [META_WIDTH-1:0]    pkt_meta;
    logic                     pkt_credit;
    logic                     rd_req;
    logic [RD_ADDR_WIDTH-1:0] rd_addr;
    logic                     rd_valid;
    logic [DATA_WIDTH-1:0]    rd_data;

    // Reference model
    logic [DATA_WIDTH-1:0] exp_mem [MEM_WORDS];
    logic [DATA_WIDTH-1:0] pkt_words [$];
    int exp_pkt_count  = 0;
    int exp_words_used = 0;
    int exp_drop_count = 0;
    bit exp_full       = 1'b0;

    int credits      = INGRESS_DEPTH;
    int cycles       = 0;
    int bench_errors = 0;
    int errors_seen  = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    clock_gen clkgen (
        .clk   (clk),
        .reset (reset)
    );

    packet_capture dut (.*);

    capture_checker chk (.*);

    bind packet_capture capture_asserts u_asserts (
        .clk        (clk),
        .reset      (reset),
        .pkt_valid  (pkt_valid),
        .pkt_credit (pkt_credit),
        .rd_req     (rd_req),
        .rd_valid   (rd_valid),
        .words_used (words_used)
    );

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout: run exceeded the limit of %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    // One clock that collects returned credits and idles the inputs
    task automatic tick();
        @(posedge clk);
        if (pkt_credit)
            credits++;
        pkt_valid <= 1'b0;
        rd_req    <= 1'b0;
    endtask

    // ========================================================================
    // Model of the writer layout
    // ========================================================================
    function automatic void model_packet(input int len, input logic [META_WIDTH-1:0] meta,
                                         input bit capture_on);
        capture_word_u hdr;
        int            n;
        n = (len + DATA_BYTES - 1) / DATA_BYTES;
        if (exp_full)
            exp_drop_count++;
        else if (capture_on)
        begin
            // Header plus payload must end inside memory
            if (exp_words_used + n + 1 > MEM_WORDS)
            begin
                exp_full = 1'b1;
                exp_drop_count++;
            end
            else
            begin
                hdr              = '0;
                hdr.hdr.byte_len = 16'(len);
                hdr.hdr.meta     = meta;
                exp_mem[exp_words_used] = hdr;
                for (int i = 0; i < n; i++)
                    exp_mem[exp_words_used + 1 + i] = pkt_words[i];
                exp_pkt_count++;
                exp_words_used += n + 1;
            end
        end
    endfunction

    // ========================================================================
    // Stimulus and reads
    // ========================================================================
    task automatic send_packet(input bit capture_on, input int max_gap);
        int                    len;
        int                    n;
        int                    gap;
        logic [META_WIDTH-1:0] meta;
        capture_word_u         w;
        len  = 1 + ($urandom % 96);
        n    = (len + DATA_BYTES - 1) / DATA_BYTES;
        meta = $urandom;
        gap  = $urandom % (max_gap + 1);
        pkt_words.delete();
        for (int i = 0; i < n; i++)
        begin
            // Empty bytes of the last word go out as zero
            for (int b = 0; b < DATA_BYTES; b++)
                w.bytes[b] = (i * DATA_BYTES + b < len) ? 8'($urandom) : 8'h00;
            pkt_words.push_back(w);
        end
        model_packet(len, meta, capture_on);
        repeat (gap) tick();
        for (int i = 0; i < n; i++)
        begin
            tick();
            while (credits == 0)
                tick();
            pkt_valid <= 1'b1;
            pkt_data  <= pkt_words[i];
            pkt_eop   <= (i == n - 1);
            pkt_mty   <= (i == n - 1) ? 3'(n * DATA_BYTES - len) : 3'd0;
            pkt_meta  <= meta;
            credits--;
        end
    endtask

    task automatic drain();
        while (credits != INGRESS_DEPTH)
            tick();
        repeat (10) tick();
    endtask

    task automatic read_check(input logic [RD_ADDR_WIDTH-1:0] addr,
                              input logic [DATA_WIDTH-1:0] value);
        tick();
        rd_req  <= 1'b1;
        rd_addr <= addr;
        chk.expect_read(addr, value);
    endtask

    task automatic read_all();
        read_check(REG_MEM_SIZE, 64'(MEM_WORDS));
        read_check(REG_META_WIDTH, 64'(META_WIDTH));
        read_check(REG_PKT_COUNT, 64'(exp_pkt_count));
        read_check(REG_WORDS_USED, 64'(exp_words_used));
        read_check(REG_DROP_COUNT, 64'(exp_drop_count));
        for (int a = 0; a < exp_words_used; a++)
            read_check(MEM_BASE + 9'(a), exp_mem[a]);
        repeat (5) tick();
    endtask

    task automatic end_test(input string name);
        int errs;
        if (chk.pending_reads() != 0)
        begin
            $display("%s: %0d read responses never arrived", name, chk.pending_reads());
            bench_errors++;
        end
        errs = chk.errors + dut.u_asserts.failures + bench_errors - errors_seen;
        errors_seen += errs;
        if (errs == 0)
            tests_passed++;
        else
            tests_failed++;
        $display("Test %-16s %s (%0d errors)", name, (errs == 0) ? "ok" : "FAILED", errs);
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial
    begin
        int n;
        void'($urandom(32'hc688));
        en        = 1'b1;
        pkt_valid = 1'b0;
        pkt_data  = '0;
        pkt_eop   = 1'b0;
        pkt_mty   = '0;
        pkt_meta  = '0;
        rd_req    = 1'b0;
        rd_addr   = '0;
        do
            tick();
        while (reset);

        read_all();
        read_check(9'd5, 64'd0);
        repeat (5) tick();
        end_test("info_registers");

        send_packet(1'b1, 0);
        drain();
        read_all();
        end_test("single_packet");

        // Alternating back-to-back and gapped packets
        for (int i = 0; i < 20; i++)
            send_packet(1'b1, (i % 2) * MAX_GAP);
        drain();
        read_all();
        end_test("stream");

        tick();
        en <= 1'b0;
        for (int i = 0; i < 4; i++)
            send_packet(1'b0, MAX_GAP);
        drain();
        en <= 1'b1;
        read_all();
        end_test("capture_disabled");

        n = 0;
        while (!exp_full && n < FILL_LIMIT)
        begin
            send_packet(1'b1, $urandom % 2);
            n++;
        end
        if (!exp_full)
        begin
            $display("memory_full: memory never filled after %0d packets", n);
            bench_errors++;
        end
        for (int i = 0; i < 3; i++)
            send_packet(1'b1, MAX_GAP);
        drain();
        read_all();
        end_test("memory_full");

        $display("Tests passed %0d, failed %0d, reads checked %0d, errors %0d",
                 tests_passed, tests_failed, chk.reads_checked, errors_seen);
        if (tests_failed == 0 && errors_seen == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: bench/capture_checker.sv
module capture_checker (
    input logic                                 clk,
    input logic                                 reset,
    input logic                                 en,
    input logic                                 pkt_valid,
    input logic [capture_pkg::DATA_WIDTH-1:0]    pkt_data,
    input logic                                 pkt_eop,
    input logic [2:0]                           pkt_mty,
    input logic [capture_pkg::META_WIDTH-1:0]    pkt_meta,
    input logic                                 pkt_credit,
    input logic                                 rd_req,
    input logic [capture_pkg::RD_ADDR_WIDTH-1:0] rd_addr,
    input logic                                 rd_valid,
    input logic [capture_pkg::DATA_WIDTH-1:0]    rd_data
);
    timeunit 1ns;
    timeprecision 100ps;
    import capture_pkg::*;

    int errors        = 0;
    int reads_checked = 0;
    int outstanding   = 0;

    // Expected responses, oldest first
    logic [RD_ADDR_WIDTH-1:0] exp_addr_q [$];
    logic [DATA_WIDTH-1:0]    exp_data_q [$];

    function automatic void expect_read(input logic [RD_ADDR_WIDTH-1:0] addr,
                                        input logic [DATA_WIDTH-1:0] value);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(value);
    endfunction

    function automatic int pending_reads();
        return exp_data_q.size();
    endfunction

    // ========================================================================
    // Credit return
    // ========================================================================
    always @(posedge clk)
    begin
        if (reset)
            outstanding = 0;
        else
        begin
            if (pkt_credit)
            begin
                if (outstanding == 0)
                begin
                    errors++;
                    $display("Credit returned at %0t with no word in flight", $time);
                end
                else
                    outstanding--;
            end
            if (pkt_valid)
                outstanding++;
        end
    end

    // ========================================================================
    // Read responses
    // ========================================================================
    always @(posedge clk)
    begin
        logic [RD_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]    value;
        if (!reset && rd_valid)
        begin
            if (exp_data_q.size() == 0)
            begin
                errors++;
                $display("Read response at %0t with no read outstanding", $time);
            end
            else
            begin
                addr  = exp_addr_q.pop_front();
                value = exp_data_q.pop_front();
                reads_checked++;
                if (rd_data !== value)
                begin
                    errors++;
                    $display("mismatch at %0t: address %0d read %h, expected %h",
                             $time, addr, rd_data, value);
                end
            end
        end
    end

endmodule

// File: bench/capture_asserts.sv
module capture_asserts (
    input logic       clk,
    input logic       reset,
    input logic       pkt_valid,
    input logic       pkt_credit,
    input logic       rd_req,
    input logic       rd_valid,
    input logic [8:0] words_used
);
    timeunit 1ns;
    timeprecision 100ps;
    import capture_pkg::*;

    int credits  = INGRESS_DEPTH;
    int failures = 0;

    // Sender side credit balance
    always @(posedge clk)
    begin
        if (reset)
            credits <= INGRESS_DEPTH;
        else
            credits <= credits - (pkt_valid ? 1 : 0) + (pkt_credit ? 1 : 0);
    end

    no_send_without_credit: assert property (@(posedge clk) disable iff (reset)
        pkt_valid |-> credits > 0)
    else
    begin
        $error("stream word sent while the sender held no credit");
        failures++;
    end

    read_latency: assert property (@(posedge clk) disable iff (reset)
        rd_req |-> ##2 rd_valid)
    else
    begin
        $error("read response did not arrive two cycles after the request");
        failures++;
    end

    no_stray_valid: assert property (@(posedge clk) disable iff (reset)
        rd_valid |-> $past(rd_req, 2))
    else
    begin
        $error("read response without a request two cycles earlier");
        failures++;
    end

    // Memory fill level
    words_in_range: assert property (@(posedge clk) disable iff (reset)
        words_used <= 9'(MEM_WORDS))
    else
    begin
        $error("words_used went past the memory size");
        failures++;
    end

endmodule

// File: bench/clock_gen.sv
module clock_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 3;

    initial
    begin
        clk   = 1'b0;
        reset = 1'b1;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Release reset after the third rising edge
    initial
    begin
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: design/packet_capture.sv
module packet_capture (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 en,
    input  logic                                 pkt_valid,
    input  logic [capture_pkg::DATA_WIDTH-1:0]    pkt_data,
    input  logic                                 pkt_eop,
    input  logic [2:0]                           pkt_mty,
    input  logic [capture_pkg::META_WIDTH-1:0]    pkt_meta,
    output logic                                 pkt_credit,
    input  logic                                 rd_req,
    input  logic [capture_pkg::RD_ADDR_WIDTH-1:0] rd_addr,
    output logic                                 rd_valid,
    output logic [capture_pkg::DATA_WIDTH-1:0]    rd_data
);

    // Statistics from writer to readout
    logic [15:0] pkt_count;
    logic [8:0]  words_used;
    logic [15:0] drop_count;

    ingress_word_if word_bus ();
    capture_mem_if  mem_bus ();

    // ========================================================================
    // Input side
    // ========================================================================
    capture_ingress u_ingress (
        .clk        (clk),
        .reset      (reset),
        .pkt_valid  (pkt_valid),
        .pkt_data   (pkt_data),
        .pkt_eop    (pkt_eop),
        .pkt_mty    (pkt_mty),
        .pkt_meta   (pkt_meta),
        .pkt_credit (pkt_credit),
        .word       (word_bus.ingress)
    );

    // ========================================================================
    // Capture path
    // ========================================================================
    capture_writer u_writer (
        .clk        (clk),
        .reset      (reset),
        .en         (en),
        .word       (word_bus.writer),
        .mem        (mem_bus.writer),
        .pkt_count  (pkt_count),
        .words_used (words_used),
        .drop_count (drop_count)
    );

    capture_ram u_ram (
        .clk (clk),
        .mem (mem_bus.ram)
    );

    // Register and memory reads
    capture_readout u_readout (
        .clk        (clk),
        .reset      (reset),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .mem        (mem_bus.reader),
        .pkt_count  (pkt_count),
        .words_used (words_used),
        .drop_count (drop_count)
    );

endmodule

// File: design/capture_readout.sv
module capture_readout (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 rd_req,
    input  logic [capture_pkg::RD_ADDR_WIDTH-1:0] rd_addr,
    output logic                                 rd_valid,
    output logic [capture_pkg::DATA_WIDTH-1:0]    rd_data,
    capture_mem_if.reader                        mem,
    input  logic [15:0]                          pkt_count,
    input  logic [8:0]                           words_used,
    input  logic [15:0]                          drop_count
);
    import capture_pkg::*;

    logic                  is_mem;
    logic [DATA_WIDTH-1:0] reg_value;
    logic                  req_q;
    logic                  is_mem_q;
    logic [DATA_WIDTH-1:0] reg_q;

    // ========================================================================
    // Address decode, stage one
    // ========================================================================
    assign is_mem      = (rd_addr >= MEM_BASE);
    assign mem.rd_en   = rd_req && is_mem;
    assign mem.rd_addr = rd_addr[MEM_ADDR_WIDTH-1:0];

    // Unmapped addresses read as zero
    always_comb
    begin
        case (rd_addr)
            REG_MEM_SIZE:   reg_value = 64'(MEM_WORDS);
            REG_META_WIDTH: reg_value = 64'(META_WIDTH);
            REG_PKT_COUNT:  reg_value = {48'd0, pkt_count};
            REG_WORDS_USED: reg_value = {55'd0, words_used};
            REG_DROP_COUNT: reg_value = {48'd0, drop_count};
            default:        reg_value = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        is_mem_q <= is_mem;
        reg_q    <= reg_value;
        // Stage two, RAM word arrives alongside the held register value
        rd_data  <= is_mem_q ? mem.rd_word : reg_q;
    end

    // Valid pipeline, two cycles behind the request
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            req_q    <= 1'b0;
            rd_valid <= 1'b0;
        end
        else
        begin
            req_q    <= rd_req;
            rd_valid <= req_q;
        end
    end

endmodule

// File: capture/capture_ram.sv
module capture_ram (
    input  logic       clk,
    capture_mem_if.ram mem
);
    import capture_pkg::*;

    capture_word_u ram [MEM_WORDS];

    // Single write port
    always_ff @(posedge clk)
    begin
        if (mem.wr_en)
            ram[mem.wr_addr] <= mem.wr_word;
    end

    // Read data registered once, held when idle
    always_ff @(posedge clk)
    begin
        if (mem.rd_en)
            mem.rd_word <= ram[mem.rd_addr];
    end

endmodule

// File: capture/capture_writer.sv
module capture_writer (
    input  logic          clk,
    input  logic          reset,
    input  logic          en,
    ingress_word_if.writer word,
    capture_mem_if.writer  mem,
    output logic [15:0]   pkt_count,
    output logic [8:0]    words_used,
    output logic [15:0]   drop_count
);
    import capture_pkg::*;

    logic [2:0]            state;
    logic [8:0]            base_ptr;
    logic [8:0]            wr_ptr;
    logic [2:0]            last_mty;
    logic [META_WIDTH-1:0] last_meta;
    logic                  take;
    logic                  capturing;
    logic                  fits;
    logic [8:0]            pay_words;
    capture_word_u         hdr_word;

    // Every valid word is consumed except in the header cycle
    assign word.word_pop = word.word_valid && (state != WR_HEADER);
    assign take          = word.word_pop;

    // en only matters at the first word of a packet
    assign capturing = (state == WR_CAPTURE) || ((state == WR_IDLE) && en);

    // Next payload address still inside memory
    assign fits      = (wr_ptr < 9'(MEM_WORDS));
    assign pay_words = wr_ptr - base_ptr - 9'd1;

    assign words_used = base_ptr;

    // ========================================================================
    // Header assembly
    // ========================================================================
    always_comb
    begin
        hdr_word.hdr.reserved = '0;
        hdr_word.hdr.meta     = last_meta;
        hdr_word.hdr.byte_len = {4'd0, pay_words, 3'd0} - {13'd0, last_mty};
    end

    // Payload in its pop cycle, header one cycle after the last pop
    always_comb
    begin
        mem.wr_en   = 1'b0;
        mem.wr_addr = wr_ptr[MEM_ADDR_WIDTH-1:0];
        mem.wr_word = word.word_data;
        if (state == WR_HEADER)
        begin
            mem.wr_en   = 1'b1;
            mem.wr_addr = base_ptr[MEM_ADDR_WIDTH-1:0];
            mem.wr_word = hdr_word;
        end
        else if (take && capturing && fits)
        begin
            mem.wr_en = 1'b1;
        end
    end

    // Last word fields, kept for the header
    always_ff @(posedge clk)
    begin
        if (take && word.word_eop)
        begin
            last_mty  <= word.word_mty;
            last_meta <= word.word_meta;
        end
    end

    // ========================================================================
    // FSM and counters
    // ========================================================================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= WR_IDLE;
            base_ptr   <= '0;
            wr_ptr     <= 9'd1;
            pkt_count  <= '0;
            drop_count <= '0;
        end
        else
        begin
            case (state)
                WR_IDLE, WR_CAPTURE:
                begin
                    if (take)
                    begin
                        if (!capturing)
                        begin
                            // Disabled packet, drained but not counted
                            state <= word.word_eop ? WR_IDLE : WR_DISCARD;
                        end
                        else if (!fits)
                        begin
                            // Overflow, roll back and stay full until reset
                            wr_ptr <= base_ptr + 9'd1;
                            state  <= WR_FULL;
                            if (word.word_eop)
                                drop_count <= drop_count + 16'd1;
                        end
                        else
                        begin
                            wr_ptr <= wr_ptr + 9'd1;
                            state  <= word.word_eop ? WR_HEADER : WR_CAPTURE;
                        end
                    end
                end
                WR_HEADER:
                begin
                    pkt_count <= pkt_count + 16'd1;
                    base_ptr  <= wr_ptr;
                    wr_ptr    <= wr_ptr + 9'd1;
                    state     <= WR_IDLE;
                end
                WR_DISCARD:
                begin
                    if (take && word.word_eop)
                        state <= WR_IDLE;
                end
                WR_FULL:
                begin
                    // Every packet end counts as a drop
                    if (take && word.word_eop)
                        drop_count <= drop_count + 16'd1;
                end
                default:
                begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

endmodule

// File: capture/capture_ingress.sv
module capture_ingress (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              pkt_valid,
    input  logic [capture_pkg::DATA_WIDTH-1:0] pkt_data,
    input  logic                              pkt_eop,
    input  logic [2:0]                        pkt_mty,
    input  logic [capture_pkg::META_WIDTH-1:0] pkt_meta,
    output logic                              pkt_credit,
    ingress_word_if.ingress                   word
);
    import capture_pkg::*;

    // Storage, one array per field
    logic [DATA_WIDTH-1:0]     data_mem [INGRESS_DEPTH];
    logic                      eop_mem  [INGRESS_DEPTH];
    logic [2:0]                mty_mem  [INGRESS_DEPTH];
    logic [META_WIDTH-1:0]     meta_mem [INGRESS_DEPTH];

    logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [FIFO_PTR_WIDTH:0]   fill;

    // ========================================================================
    // Write side
    // ========================================================================
    // Sender spends a credit per word, so there is always room here
    always_ff @(posedge clk)
    begin
        if (pkt_valid)
        begin
            data_mem[wr_ptr] <= pkt_data;
            eop_mem[wr_ptr]  <= pkt_eop;
            mty_mem[wr_ptr]  <= pkt_mty;
            meta_mem[wr_ptr] <= pkt_meta;
        end
    end

    // ========================================================================
    // Pointers, fill level and credit return
    // ========================================================================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
            pkt_credit <= 1'b0;
        end
        else
        begin
            if (pkt_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (word.word_pop)
                rd_ptr <= rd_ptr + 1'b1;

            if (pkt_valid && !word.word_pop)
                fill <= fill + 1'b1;
            else if (!pkt_valid && word.word_pop)
                fill <= fill - 1'b1;

            // One credit per consumed word, a cycle after the pop
            pkt_credit <= word.word_pop;
        end
    end

    // Head of FIFO, read straight from storage
    assign word.word_valid = (fill != '0);
    assign word.word_data  = data_mem[rd_ptr];
    assign word.word_eop   = eop_mem[rd_ptr];
    assign word.word_mty   = mty_mem[rd_ptr];
    assign word.word_meta  = meta_mem[rd_ptr];

endmodule

// File: common/capture_ifs.sv
interface ingress_word_if;
    import capture_pkg::*;

    logic                  word_valid;
    logic                  word_pop;
    logic [DATA_WIDTH-1:0] word_data;
    logic                  word_eop;
    logic [2:0]            word_mty;
    logic [META_WIDTH-1:0] word_meta;

    // Head word leaves the FIFO at the edge where word_pop is high
    modport ingress (output word_valid, word_data, word_eop, word_mty, word_meta,
                     input word_pop);
    modport writer  (input word_valid, word_data, word_eop, word_mty, word_meta,
                     output word_pop);
endinterface

interface capture_mem_if;
    import capture_pkg::*;

    logic                      wr_en;
    logic [MEM_ADDR_WIDTH-1:0] wr_addr;
    capture_word_u             wr_word;
    logic                      rd_en;
    logic [MEM_ADDR_WIDTH-1:0] rd_addr;
    capture_word_u             rd_word;

    modport writer (output wr_en, wr_addr, wr_word);
    modport reader (output rd_en, rd_addr, input rd_word);
    modport ram    (input wr_en, wr_addr, wr_word, rd_en, rd_addr, output rd_word);
endinterface

// File: common/capture_pkg.sv
package capture_pkg;

    // ========================================================================
    // Stream and memory sizes
    // ========================================================================
    localparam int DATA_BYTES     = 8;
    localparam int DATA_WIDTH     = 64;
    localparam int META_WIDTH     = 32;

    // Ingress FIFO depth, also the sender's initial credit count
    localparam int INGRESS_DEPTH  = 16;
    localparam int FIFO_PTR_WIDTH = $clog2(INGRESS_DEPTH);

    localparam int MEM_WORDS      = 256;
    localparam int MEM_ADDR_WIDTH = 8;
    localparam int RD_ADDR_WIDTH  = 9;

    // ========================================================================
    // Read port address map
    // ========================================================================
    localparam logic [RD_ADDR_WIDTH-1:0] REG_MEM_SIZE   = 9'd0;
    localparam logic [RD_ADDR_WIDTH-1:0] REG_META_WIDTH = 9'd1;
    localparam logic [RD_ADDR_WIDTH-1:0] REG_PKT_COUNT  = 9'd2;
    localparam logic [RD_ADDR_WIDTH-1:0] REG_WORDS_USED = 9'd3;
    localparam logic [RD_ADDR_WIDTH-1:0] REG_DROP_COUNT = 9'd4;
    localparam logic [RD_ADDR_WIDTH-1:0] MEM_BASE       = 9'd256;

    // Writer FSM encodings
    localparam logic [2:0] WR_IDLE    = 3'd0;
    localparam logic [2:0] WR_CAPTURE = 3'd1;
    localparam logic [2:0] WR_HEADER  = 3'd2;
    localparam logic [2:0] WR_DISCARD = 3'd3;
    localparam logic [2:0] WR_FULL    = 3'd4;

    // ========================================================================
    // Capture memory word
    // ========================================================================
    // Header word sits at the packet base, payload follows it
    typedef struct packed {
        logic [15:0]           reserved;
        logic [META_WIDTH-1:0] meta;
        logic [15:0]           byte_len;
    } capture_hdr_t;

    // Byte 0 is the first byte of the word on the stream
    typedef union packed {
        capture_hdr_t                hdr;
        logic [DATA_BYTES-1:0][7:0] bytes;
    } capture_word_u;

endpackage
